// File: dc_calc.sv
// dc over the first S top and S left references, recomputed every issued sub-block
`timescale 1ns/1ps
`default_nettype none

module dc_calc
  import posi_pkg::*;
#(
  parameter int PIXEL_WIDTH = 8
) (
  input  wire logic                           clk,
  input  wire logic                           rstn,
  input  blk_size_e                           size_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] ref_t_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] ref_l_i,
  pred_ref_if.dc                              ref_o
);

  // 64 pixels at most, plus the rounding term
  localparam int SUM_W = PIXEL_WIDTH + 6;

  logic [5:0]       blk_len;
  logic [SUM_W-1:0] sum_d;
  logic [SUM_W-1:0] sum_q;
  blk_size_e        size_q;
  logic [5:0]       len_q;
  logic [2:0]       dc_shift;
  logic [SUM_W-1:0] dc_full;

  assign blk_len = 6'(SUB_DIM) << size_i;

  always_comb begin
    sum_d = '0;
    for (int k = 0; k < REF_NUM; k++) begin
      if (k < int'(blk_len)) begin
        sum_d = sum_d
              + SUM_W'(ref_t_i[(REF_NUM - 1 - k) * PIXEL_WIDTH +: PIXEL_WIDTH])
              + SUM_W'(ref_l_i[(REF_NUM - 1 - k) * PIXEL_WIDTH +: PIXEL_WIDTH]);
      end
    end
  end

  //------------------------------
  // stage 1, sum
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sum_q  <= '0;
      size_q <= SIZE_04;
    end else begin
      sum_q  <= sum_d;
      size_q <= size_i;
    end
  end

  // round and divide by 2S
  assign len_q    = 6'(SUB_DIM) << size_q;
  assign dc_shift = {1'b0, size_q} + 3'd3;
  assign dc_full  = (sum_q + SUM_W'(len_q)) >> dc_shift;

  // stage 2
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ref_o.dc_pix <= '0;
    end else begin
      ref_o.dc_pix <= dc_full[PIXEL_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: info_delay.sv
// position must be aligned to the block size, otherwise the or of the offsets is wrong
`timescale 1ns/1ps
`default_nettype none

module info_delay
  import posi_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rstn,
  input  wire logic       issue_i,
  input  wire logic [2:0] sub_x_i,
  input  wire logic [2:0] sub_y_i,
  input  pred_mode_e      mode_i,
  input  blk_size_e       size_i,
  input  wire logic [7:0] position_i,
  output logic            val_ahd_o,
  output logic [3:0]      idx_x_ahd_o,
  output logic [3:0]      idx_y_ahd_o,
  output logic            val_o,
  output pred_mode_e      mode_o,
  output blk_size_e       size_o,
  output logic [7:0]      position_o
);

  logic [3:0] idx_x_d;
  logic [3:0] idx_y_d;

  logic [PIPE_DELAY-1:0]      val_q;
  logic [PIPE_DELAY-2:0][3:0] idx_x_q;
  logic [PIPE_DELAY-2:0][3:0] idx_y_q;
  logic [PIPE_DELAY-1:0][5:0] mode_q;
  logic [PIPE_DELAY-1:0][1:0] size_q;
  logic [PIPE_DELAY-1:0][7:0] pos_q;

  // block index from the interleaved position, plus the sub-block offset
  assign idx_x_d = {position_i[6], position_i[4], position_i[2], position_i[0]}
                 | {1'b0, sub_x_i};
  assign idx_y_d = {position_i[7], position_i[5], position_i[3], position_i[1]}
                 | {1'b0, sub_y_i};

  //------------------------------
  // shift lines
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_q   <= '0;
      idx_x_q <= '0;
      idx_y_q <= '0;
      mode_q  <= '0;
      size_q  <= '0;
      pos_q   <= '0;
    end else begin
      val_q   <= {val_q[PIPE_DELAY-2:0], issue_i};
      idx_x_q <= {idx_x_q[PIPE_DELAY-3:0], idx_x_d};
      idx_y_q <= {idx_y_q[PIPE_DELAY-3:0], idx_y_d};
      mode_q  <= {mode_q[PIPE_DELAY-2:0], 6'(mode_i)};
      size_q  <= {size_q[PIPE_DELAY-2:0], 2'(size_i)};
      pos_q   <= {pos_q[PIPE_DELAY-2:0], position_i};
    end
  end

  // look-ahead tap, one cycle before the data
  assign val_ahd_o   = val_q[PIPE_DELAY-2];
  assign idx_x_ahd_o = idx_x_q[PIPE_DELAY-2];
  assign idx_y_ahd_o = idx_y_q[PIPE_DELAY-2];

  // data tap
  assign val_o      = val_q[PIPE_DELAY-1];
  assign mode_o     = pred_mode_e'(mode_q[PIPE_DELAY-1]);
  assign size_o     = blk_size_e'(size_q[PIPE_DELAY-1]);
  assign position_o = pos_q[PIPE_DELAY-1];

endmodule

`default_nettype wire

// File: posi_pkg.sv
// shared codes and geometry; modes other than 1, 10 and 26 are legal and predict as DC
`default_nettype none

package posi_pkg;

  //------------------------------
  // block size code, edge = 4 << code
  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } blk_size_e;

  // only three modes are implemented
  typedef enum logic [5:0] {
    MODE_DC  = 6'd1,
    MODE_HOR = 6'd10,
    MODE_VER = 6'd26
  } pred_mode_e;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } ctrl_state_e;

  //------------------------------
  // reference pixels per side
  localparam int REF_NUM = 32;

  // sub-block edge
  localparam int SUB_DIM = 4;

  // issue to data out
  localparam int PIPE_DELAY = 3;

endpackage

`default_nettype wire

// File: posi_prediction.sv
// no back-pressure: val_o data must be taken; cfg and refs hold until the last issue
`timescale 1ns/1ps
`default_nettype none

module posi_prediction
  import posi_pkg::*;
#(
  parameter int PIXEL_WIDTH = 8
) (
  input  wire logic                           clk,
  input  wire logic                           rstn,
  input  wire logic                           start_i,
  input  wire logic [5:0]                     mode_i,
  input  wire logic [1:0]                     size_i,
  input  wire logic [7:0]                     position_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] dat_ref_t_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] dat_ref_l_i,
  output logic                                val_ahd_o,
  output logic [3:0]                          idx_4x4_x_ahd_o,
  output logic [3:0]                          idx_4x4_y_ahd_o,
  output logic [5:0]                          mode_o,
  output logic [1:0]                          size_o,
  output logic [7:0]                          position_o,
  output logic                                val_o,
  output logic [SUB_DIM*SUB_DIM*PIXEL_WIDTH-1:0] dat_pre_o
);

  logic       issue;
  logic [2:0] sub_x;
  logic [2:0] sub_y;

  pred_ref_if #(.PIXEL_WIDTH(PIXEL_WIDTH)) pred_ref ();

  //------------------------------
  // control
  pred_ctrl pred_ctrl_i (
    .clk     (clk),
    .rstn    (rstn),
    .start_i (start_i),
    .size_i  (blk_size_e'(size_i)),
    .issue_o (issue),
    .sub_x_o (sub_x),
    .sub_y_o (sub_y)
  );

  //------------------------------
  // datapath
  ref_select #(.PIXEL_WIDTH(PIXEL_WIDTH)) ref_select_i (
    .clk     (clk),
    .rstn    (rstn),
    .sub_x_i (sub_x),
    .sub_y_i (sub_y),
    .mode_i  (pred_mode_e'(mode_i)),
    .ref_t_i (dat_ref_t_i),
    .ref_l_i (dat_ref_l_i),
    .ref_o   (pred_ref.sel)
  );

  dc_calc #(.PIXEL_WIDTH(PIXEL_WIDTH)) dc_calc_i (
    .clk     (clk),
    .rstn    (rstn),
    .size_i  (blk_size_e'(size_i)),
    .ref_t_i (dat_ref_t_i),
    .ref_l_i (dat_ref_l_i),
    .ref_o   (pred_ref.dc)
  );

  pred_fill #(.PIXEL_WIDTH(PIXEL_WIDTH)) pred_fill_i (
    .clk    (clk),
    .rstn   (rstn),
    .ref_i  (pred_ref.fill),
    .pred_o (dat_pre_o)
  );

  // valid, look-ahead and cfg alongside the data
  info_delay info_delay_i (
    .clk         (clk),
    .rstn        (rstn),
    .issue_i     (issue),
    .sub_x_i     (sub_x),
    .sub_y_i     (sub_y),
    .mode_i      (pred_mode_e'(mode_i)),
    .size_i      (blk_size_e'(size_i)),
    .position_i  (position_i),
    .val_ahd_o   (val_ahd_o),
    .idx_x_ahd_o (idx_4x4_x_ahd_o),
    .idx_y_ahd_o (idx_4x4_y_ahd_o),
    .val_o       (val_o),
    .mode_o      (mode_o),
    .size_o      (size_o),
    .position_o  (position_o)
  );

endmodule

`default_nettype wire

// File: pred_ctrl.sv
// size_i must hold until the last sub-block is issued; start_i while busy is ignored
`timescale 1ns/1ps
`default_nettype none

module pred_ctrl
  import posi_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rstn,
  input  wire logic       start_i,
  input  blk_size_e       size_i,
  output logic            issue_o,
  output logic [2:0]      sub_x_o,
  output logic [2:0]      sub_y_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic [5:0]  cnt_q;
  logic [5:0]  cnt_last;
  logic        cnt_done;

  assign issue_o = start_i | (state_q == BUSY);

  // last count of the block, n - 1
  always_comb begin
    case (size_i)
      SIZE_04: cnt_last = 6'd0;
      SIZE_08: cnt_last = 6'd3;
      SIZE_16: cnt_last = 6'd15;
      default: cnt_last = 6'd63;
    endcase
  end

  assign cnt_done = (cnt_q == cnt_last);

  //------------------------------
  // sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // a single sub-block finishes in the start cycle
        if (start_i && !cnt_done) begin
          state_d = BUSY;
        end
      end
      default: begin
        if (cnt_done) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // sub-block counter
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_q <= 6'd0;
    end else if (issue_o && !cnt_done) begin
      cnt_q <= cnt_q + 6'd1;
    end else begin
      cnt_q <= 6'd0;
    end
  end

  // z-order, even bits x and odd bits y
  assign sub_x_o = {cnt_q[4], cnt_q[2], cnt_q[0]};
  assign sub_y_o = {cnt_q[5], cnt_q[3], cnt_q[1]};

endmodule

`default_nettype wire

// File: pred_fill.sv
// no edge filtering; any mode other than horizontal or vertical fills with dc
`timescale 1ns/1ps
`default_nettype none

module pred_fill
  import posi_pkg::*;
#(
  parameter int PIXEL_WIDTH = 8
) (
  input  wire logic                                   clk,
  input  wire logic                                   rstn,
  pred_ref_if.fill                                    ref_i,
  output logic [SUB_DIM*SUB_DIM*PIXEL_WIDTH-1:0]      pred_o
);

  localparam int PIX_NUM = SUB_DIM * SUB_DIM;

  logic [PIX_NUM*PIXEL_WIDTH-1:0] pred_d;

  // row 0 col 0 in the msb, row major
  always_comb begin
    pred_d = '0;
    for (int r = 0; r < SUB_DIM; r++) begin
      for (int c = 0; c < SUB_DIM; c++) begin
        case (ref_i.mode)
          MODE_VER: begin
            pred_d[(PIX_NUM - 1 - (r * SUB_DIM + c)) * PIXEL_WIDTH +: PIXEL_WIDTH] =
              ref_i.top_pix[(SUB_DIM - 1 - c) * PIXEL_WIDTH +: PIXEL_WIDTH];
          end
          MODE_HOR: begin
            pred_d[(PIX_NUM - 1 - (r * SUB_DIM + c)) * PIXEL_WIDTH +: PIXEL_WIDTH] =
              ref_i.left_pix[(SUB_DIM - 1 - r) * PIXEL_WIDTH +: PIXEL_WIDTH];
          end
          default: begin
            pred_d[(PIX_NUM - 1 - (r * SUB_DIM + c)) * PIXEL_WIDTH +: PIXEL_WIDTH] =
              ref_i.dc_pix;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pred_o <= '0;
    end else begin
      pred_o <= pred_d;
    end
  end

endmodule

`default_nettype wire

// File: pred_ref_if.sv
// fill-stage inputs; all four fields are valid in the same cycle, no handshake
`timescale 1ns/1ps
`default_nettype none

interface pred_ref_if
  import posi_pkg::*;
#(
  parameter int PIXEL_WIDTH = 8
) ();

  // pixel 0 in the msb
  logic [SUB_DIM*PIXEL_WIDTH-1:0] top_pix;
  logic [SUB_DIM*PIXEL_WIDTH-1:0] left_pix;
  pred_mode_e                     mode;
  logic [PIXEL_WIDTH-1:0]         dc_pix;

  modport sel (output top_pix, output left_pix, output mode);

  modport dc (output dc_pix);

  modport fill (input top_pix, input left_pix, input mode, input dc_pix);

endinterface

`default_nettype wire

// File: ref_select.sv
// references must hold while the block issues; output lags the issue by two cycles
`timescale 1ns/1ps
`default_nettype none

module ref_select
  import posi_pkg::*;
#(
  parameter int PIXEL_WIDTH = 8
) (
  input  wire logic                           clk,
  input  wire logic                           rstn,
  input  wire logic [2:0]                     sub_x_i,
  input  wire logic [2:0]                     sub_y_i,
  input  pred_mode_e                          mode_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] ref_t_i,
  input  wire logic [REF_NUM*PIXEL_WIDTH-1:0] ref_l_i,
  pred_ref_if.sel                             ref_o
);

  localparam int SEL_W = SUB_DIM * PIXEL_WIDTH;

  logic [SEL_W-1:0] top_d;
  logic [SEL_W-1:0] left_d;
  logic [SEL_W-1:0] top_q;
  logic [SEL_W-1:0] left_q;
  pred_mode_e       mode_q;

  // index 0 is the msb pixel, so group g sits g groups below the top
  assign top_d  = ref_t_i[(REF_NUM - SUB_DIM * (int'(sub_x_i) + 1)) * PIXEL_WIDTH +: SEL_W];
  assign left_d = ref_l_i[(REF_NUM - SUB_DIM * (int'(sub_y_i) + 1)) * PIXEL_WIDTH +: SEL_W];

  //------------------------------
  // stage 1
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      top_q  <= '0;
      left_q <= '0;
      mode_q <= pred_mode_e'(6'd0);
    end else begin
      top_q  <= top_d;
      left_q <= left_d;
      mode_q <= mode_i;
    end
  end

  // stage 2, lines up with the dc result
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ref_o.top_pix  <= '0;
      ref_o.left_pix <= '0;
      ref_o.mode     <= pred_mode_e'(6'd0);
    end else begin
      ref_o.top_pix  <= top_q;
      ref_o.left_pix <= left_q;
      ref_o.mode     <= mode_q;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_posi_prediction

out=$(./obj_dir/Vtb_posi_prediction || true)
echo "$out"

echo "$out" | grep -qx "Test passed"

// File: tb_posi_prediction.sv
// one block in flight at a time, 8-bit pixels; cfg and refs are held for the whole block
`timescale 1ns/1ps
`default_nettype none

module tb_posi_prediction
  import posi_pkg::*;
();

  localparam int PIXEL_WIDTH = 8;
  localparam int TIMEOUT_CYC = 20;
  localparam logic [PIXEL_WIDTH-1:0] CONST_PIX = PIXEL_WIDTH'('h5a);

  typedef struct packed {
    logic [1:0] size;
    logic [5:0] mode;
    logic [7:0] pos;
    logic       rnd;
    logic       restart;
  } entry_t;

  //------------------------------
  // stimulus table, positions aligned to the block size
  localparam int NUM_ENTRIES = 11;
  localparam entry_t ENTRIES [NUM_ENTRIES] = '{
    '{SIZE_04, MODE_DC,  8'h00, 1'b1, 1'b0},
    '{SIZE_04, MODE_VER, 8'h2d, 1'b1, 1'b0},
    '{SIZE_08, MODE_HOR, 8'h0c, 1'b1, 1'b0},
    '{SIZE_08, MODE_VER, 8'hb4, 1'b1, 1'b1},
    '{SIZE_16, MODE_DC,  8'h30, 1'b1, 1'b0},
    '{SIZE_16, 6'd18,    8'h90, 1'b1, 1'b1},
    '{SIZE_32, MODE_HOR, 8'h40, 1'b1, 1'b0},
    '{SIZE_32, MODE_VER, 8'hc0, 1'b1, 1'b1},
    '{SIZE_32, MODE_DC,  8'h00, 1'b0, 1'b0},
    '{SIZE_08, 6'd0,     8'h1c, 1'b0, 1'b0},
    '{SIZE_04, MODE_HOR, 8'hff, 1'b1, 1'b0}
  };

  logic                           clk;
  logic                           rstn;
  logic                           start_i;
  logic [5:0]                     mode_i;
  logic [1:0]                     size_i;
  logic [7:0]                     position_i;
  logic [REF_NUM*PIXEL_WIDTH-1:0] dat_ref_t_i;
  logic [REF_NUM*PIXEL_WIDTH-1:0] dat_ref_l_i;
  logic                           val_ahd_o;
  logic [3:0]                     idx_4x4_x_ahd_o;
  logic [3:0]                     idx_4x4_y_ahd_o;
  logic [5:0]                     mode_o;
  logic [1:0]                     size_o;
  logic [7:0]                     position_o;
  logic                           val_o;
  logic [SUB_DIM*SUB_DIM*PIXEL_WIDTH-1:0] dat_pre_o;

  logic [PIXEL_WIDTH-1:0] ref_t [REF_NUM];
  logic [PIXEL_WIDTH-1:0] ref_l [REF_NUM];
  int                     seed;

  posi_prediction #(.PIXEL_WIDTH(PIXEL_WIDTH)) posi_prediction_i (
    .clk             (clk),
    .rstn            (rstn),
    .start_i         (start_i),
    .mode_i          (mode_i),
    .size_i          (size_i),
    .position_i      (position_i),
    .dat_ref_t_i     (dat_ref_t_i),
    .dat_ref_l_i     (dat_ref_l_i),
    .val_ahd_o       (val_ahd_o),
    .idx_4x4_x_ahd_o (idx_4x4_x_ahd_o),
    .idx_4x4_y_ahd_o (idx_4x4_y_ahd_o),
    .mode_o          (mode_o),
    .size_o          (size_o),
    .position_o      (position_o),
    .val_o           (val_o),
    .dat_pre_o       (dat_pre_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //------------------------------
  // reporting
  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error: time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  //------------------------------
  // reference model
  function automatic int sub_x_of(input int k);
    return (((k >> 4) & 1) << 2) | (((k >> 2) & 1) << 1) | (k & 1);
  endfunction

  function automatic int sub_y_of(input int k);
    return (((k >> 5) & 1) << 2) | (((k >> 3) & 1) << 1) | ((k >> 1) & 1);
  endfunction

  // odd = 0 takes the even bits (x), odd = 1 the odd bits (y)
  function automatic int block_index(input int pos, input int odd);
    int idx;
    idx = 0;
    for (int i = 0; i < 4; i++) begin
      idx |= ((pos >> (2 * i + odd)) & 1) << i;
    end
    return idx;
  endfunction

  function automatic int dc_value(input int size);
    int s;
    int sum;
    s = 4 << size;
    sum = 0;
    for (int i = 0; i < s; i++) begin
      sum += int'(ref_t[i]) + int'(ref_l[i]);
    end
    // log2(s) + 1 is size + 3
    return (sum + s) >> (size + 3);
  endfunction

  function automatic int expected_pixel(input entry_t e, input int k, input int r, input int c);
    if (e.mode == MODE_VER) begin
      return int'(ref_t[4 * sub_x_of(k) + c]);
    end
    if (e.mode == MODE_HOR) begin
      return int'(ref_l[4 * sub_y_of(k) + r]);
    end
    return dc_value(int'(e.size));
  endfunction

  //------------------------------
  // stimulus
  task automatic load_refs(input logic rnd);
    for (int i = 0; i < REF_NUM; i++) begin
      ref_t[i] = rnd ? PIXEL_WIDTH'($random(seed)) : CONST_PIX;
      ref_l[i] = rnd ? PIXEL_WIDTH'($random(seed)) : CONST_PIX;
      dat_ref_t_i[(REF_NUM - 1 - i) * PIXEL_WIDTH +: PIXEL_WIDTH] = ref_t[i];
      dat_ref_l_i[(REF_NUM - 1 - i) * PIXEL_WIDTH +: PIXEL_WIDTH] = ref_l[i];
    end
  endtask

  task automatic check_output(input entry_t e, input int k);
    int got;
    for (int r = 0; r < SUB_DIM; r++) begin
      for (int c = 0; c < SUB_DIM; c++) begin
        got = int'(dat_pre_o[(15 - (r * SUB_DIM + c)) * PIXEL_WIDTH +: PIXEL_WIDTH]);
        check_value($sformatf("dat_pre_o[%0d][%0d] sub-block %0d", r, c, k), got,
                    expected_pixel(e, k, r, c));
        if (!e.rnd) begin
          check_value("dat_pre_o constant", got, int'(CONST_PIX));
        end
      end
    end
    check_value("mode_o", int'(mode_o), int'(e.mode));
    check_value("size_o", int'(size_o), int'(e.size));
    check_value("position_o", int'(position_o), int'(e.pos));
  endtask

  // called at posedge + 2 ns, returns there
  task automatic run_entry(input entry_t e);
    int n;
    int cyc;
    int seen;
    int ahd_seen;
    n = 1 << (2 * int'(e.size));
    load_refs(e.rnd);
    mode_i     = e.mode;
    size_i     = e.size;
    position_i = e.pos;
    start_i    = 1'b1;
    cyc        = 0;
    seen       = 0;
    ahd_seen   = 0;
    while (seen < n) begin
      @(negedge clk);
      check_value("val_ahd_o", int'(val_ahd_o), int'(cyc >= 2 && cyc < n + 2));
      check_value("val_o", int'(val_o), int'(cyc >= 3 && cyc < n + 3));
      if (val_ahd_o) begin
        check_value("idx_4x4_x_ahd_o", int'(idx_4x4_x_ahd_o),
                    block_index(int'(e.pos), 0) | sub_x_of(ahd_seen));
        check_value("idx_4x4_y_ahd_o", int'(idx_4x4_y_ahd_o),
                    block_index(int'(e.pos), 1) | sub_y_of(ahd_seen));
        ahd_seen++;
      end
      if (val_o) begin
        check_output(e, seen);
        seen++;
      end
      assert (cyc < n + TIMEOUT_CYC) else begin
        $display("timeout: block did not deliver all sub-blocks in time");
        stop_on_failure();
      end
      @(posedge clk);
      #2;
      cyc++;
      // extra start while busy must be ignored
      start_i = e.restart && (cyc == 2);
    end
    repeat (4) begin
      @(negedge clk);
      check_value("val_o after block", int'(val_o), 0);
      check_value("val_ahd_o after block", int'(val_ahd_o), 0);
      @(posedge clk);
      #2;
    end
  endtask

  //------------------------------
  // main sequence
  initial begin
    seed        = 32'he3aa;
    rstn        = 1'b0;
    start_i     = 1'b0;
    mode_i      = '0;
    size_i      = '0;
    position_i  = '0;
    dat_ref_t_i = '0;
    dat_ref_l_i = '0;
    repeat (16) begin
      @(negedge clk);
      check_value("val_o in reset", int'(val_o), 0);
      check_value("val_ahd_o in reset", int'(val_ahd_o), 0);
    end
    @(posedge clk);
    #2;
    rstn = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("val_o before start", int'(val_o), 0);
      check_value("val_ahd_o before start", int'(val_ahd_o), 0);
      @(posedge clk);
      #2;
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(ENTRIES[i]);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
posi_pkg.sv
pred_ref_if.sv
pred_ctrl.sv
ref_select.sv
dc_calc.sv
pred_fill.sv
info_delay.sv
posi_prediction.sv
tb_posi_prediction.sv
